// ==== common/rs_pkg.sv ====
/*
 * Shared sizes and types for the reservation station.
 * The entry count must stay a power of two so that rs_idx_t covers it exactly.
 * The src2 word is a tag or an immediate, and a separate flag says which.
 */

package rs_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    // Station depth
    localparam int rs_size = 8;

    // Physical register tag
    localparam int tag_w = 6;

    // Operand word, wide enough for a tag or a small immediate
    localparam int opnd_w = 8;

    ////////////////////
    // Types
    ////////////////////

    // Entry index
    typedef logic [$clog2(rs_size)-1:0] rs_idx_t;

    // ALU operation codes
    typedef enum logic [3:0] {
        op_add = 4'h0,
        op_sub = 4'h1,
        op_and = 4'h2,
        op_or  = 4'h3,
        op_xor = 4'h4,
        op_sll = 4'h5,
        op_srl = 4'h6,
        op_slt = 4'h7
    } rs_op_t;

    // Tag reading of the operand word
    typedef struct packed {
        logic [opnd_w-tag_w-1:0] unused;
        logic [tag_w-1:0]        tag;
    } rs_tag_view_t;

    // Second source operand
    // Read as tag_view while it waits on a producer, as imm otherwise
    typedef union packed {
        rs_tag_view_t      tag_view;
        logic [opnd_w-1:0] imm;
    } rs_operand_u;

endpackage

// ==== files.f ====
common/rs_pkg.sv
rs/rs_alloc.sv
rs/rs_entry.sv
rs/rs_select.sv
src/rs_top.sv
verif/rs_checker.sv
verif/rs_tb.sv

// ==== rs/rs_alloc.sv ====
/*
 * Allocation for the station, one instruction per cycle.
 * alloc_ready only sees the valid bits at the start of the cycle.
 * An alloc_valid with no free entry is dropped.
 */

`timescale 1ns/100ps

module rs_alloc (
    input  logic [rs_pkg::rs_size-1:0] entry_valid,
    input  logic                       alloc_valid,
    output logic [rs_pkg::rs_size-1:0] entry_write,
    output logic                       alloc_ready
);

    import rs_pkg::*;

    ////////////////////
    // Free search
    ////////////////////

    // Lowest invalid entry
    rs_idx_t free_idx;
    // Some entry is free
    logic    free_found;

    // Priority encoder
    // Walks down so the lowest free index is written last
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = rs_size - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                free_found = 1'b1;
                free_idx   = rs_idx_t'(i);
            end
        end
    end

    ////////////////////
    // Write strobe
    ////////////////////

    // One-hot write, only when a request meets a free slot
    always_comb begin
        entry_write           = '0;
        entry_write[free_idx] = alloc_valid & free_found;
    end

    // Station can take one more
    assign alloc_ready = free_found;

    ////////////////////
    // Checks
    ////////////////////

    // Write is at most one-hot and never lands on a live entry
    always_comb begin
        assert final ($onehot0(entry_write) && ((entry_write & entry_valid) == '0))
            else $error("rs_alloc: bad write strobe %b, valid %b", entry_write, entry_valid);
    end

endmodule

// ==== rs/rs_entry.sv ====
/*
 * One station entry holding an instruction until both operands are ready.
 * Flush beats write, so an allocation in a flush cycle is lost.
 * Wakeup only looks at src2 through the tag view when it is not an immediate.
 */

`timescale 1ns/100ps

module rs_entry (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     write,
    input  logic                     clear,
    input  logic                     flush,
    input  rs_pkg::rs_op_t           alloc_op,
    input  logic [rs_pkg::tag_w-1:0] alloc_dest,
    input  logic [rs_pkg::tag_w-1:0] alloc_src1_tag,
    input  logic                     alloc_src1_ready,
    input  rs_pkg::rs_operand_u      alloc_src2,
    input  logic                     alloc_src2_imm,
    input  logic                     alloc_src2_ready,
    input  logic                     cdb_valid,
    input  logic [rs_pkg::tag_w-1:0] cdb_tag,
    output logic                     valid,
    output logic                     ready,
    output rs_pkg::rs_op_t           op,
    output logic [rs_pkg::tag_w-1:0] dest,
    output logic [rs_pkg::tag_w-1:0] src1_tag,
    output rs_pkg::rs_operand_u      src2,
    output logic                     src2_imm
);

    import rs_pkg::*;

    // Per-operand ready flags
    logic             src1_rdy;
    logic             src2_rdy;
    // Src2 tags as seen through the union
    logic [tag_w-1:0] src2_new_tag;
    logic [tag_w-1:0] src2_old_tag;
    // CDB matches against incoming and stored tags
    logic             src1_hit_new;
    logic             src2_hit_new;
    logic             src1_hit_old;
    logic             src2_hit_old;

    ////////////////////
    // Wakeup match
    ////////////////////

    assign src2_new_tag = alloc_src2.tag_view.tag;
    assign src2_old_tag = src2.tag_view.tag;

    // Broadcast in the allocation cycle counts
    assign src1_hit_new = cdb_valid && (cdb_tag == alloc_src1_tag);
    assign src2_hit_new = cdb_valid && !alloc_src2_imm && (cdb_tag == src2_new_tag);
    // Later broadcasts hit the stored tags
    assign src1_hit_old = cdb_valid && (cdb_tag == src1_tag);
    assign src2_hit_old = cdb_valid && !src2_imm && (cdb_tag == src2_old_tag);

    ////////////////////
    // Control state
    ////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (write) begin
            valid <= 1'b1;
        end else if (clear) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            src1_rdy <= 1'b0;
            src2_rdy <= 1'b0;
        end else if (write) begin
            src1_rdy <= alloc_src1_ready | src1_hit_new;
            // Immediate needs no producer
            src2_rdy <= alloc_src2_ready | alloc_src2_imm | src2_hit_new;
        end else begin
            if (src1_hit_old) src1_rdy <= 1'b1;
            if (src2_hit_old) src2_rdy <= 1'b1;
        end
    end

    ////////////////////
    // Payload
    ////////////////////

    always_ff @(posedge clock) begin
        if (write) begin
            op       <= alloc_op;
            dest     <= alloc_dest;
            src1_tag <= alloc_src1_tag;
            src2     <= alloc_src2;
            src2_imm <= alloc_src2_imm;
        end
    end

    // Fully ready, offered to the selector
    assign ready = valid & src1_rdy & src2_rdy;

    // Allocator and selector never aim at the same entry in one cycle
    assert property (@(posedge clock) disable iff (!rst_n) !(write && clear))
        else $error("rs_entry: write and clear together");

endmodule

// ==== rs/rs_select.sv ====
/*
 * Issue select, lowest ready index wins.
 * Outputs are combinational from the entries, zero while nothing is ready.
 * The clear strobe only fires when the functional unit takes the issue.
 */

`timescale 1ns/100ps

module rs_select (
    input  logic [rs_pkg::rs_size-1:0] entry_ready,
    input  rs_pkg::rs_op_t             entry_op       [rs_pkg::rs_size],
    input  logic [rs_pkg::tag_w-1:0]   entry_dest     [rs_pkg::rs_size],
    input  logic [rs_pkg::tag_w-1:0]   entry_src1_tag [rs_pkg::rs_size],
    input  rs_pkg::rs_operand_u        entry_src2     [rs_pkg::rs_size],
    input  logic [rs_pkg::rs_size-1:0] entry_src2_imm,
    input  logic                       fu_ready,
    output logic [rs_pkg::rs_size-1:0] entry_clear,
    output logic                       issue_valid,
    output rs_pkg::rs_op_t             issue_op,
    output logic [rs_pkg::tag_w-1:0]   issue_dest,
    output logic [rs_pkg::tag_w-1:0]   issue_src1_tag,
    output rs_pkg::rs_operand_u        issue_src2,
    output logic                       issue_src2_imm
);

    import rs_pkg::*;

    // Chosen entry
    rs_idx_t sel_idx;
    // Any entry ready
    logic    sel_found;

    ////////////////////
    // Priority pick
    ////////////////////

    // Downward walk leaves the lowest ready index
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = rs_size - 1; i >= 0; i--) begin
            if (entry_ready[i]) begin
                sel_found = 1'b1;
                sel_idx   = rs_idx_t'(i);
            end
        end
    end

    assign issue_valid = sel_found;

    ////////////////////
    // Issue mux
    ////////////////////

    always_comb begin
        // Quiet bus when idle
        issue_op       = op_add;
        issue_dest     = '0;
        issue_src1_tag = '0;
        issue_src2     = '0;
        issue_src2_imm = 1'b0;
        if (sel_found) begin
            issue_op       = entry_op[sel_idx];
            issue_dest     = entry_dest[sel_idx];
            issue_src1_tag = entry_src1_tag[sel_idx];
            issue_src2     = entry_src2[sel_idx];
            issue_src2_imm = entry_src2_imm[sel_idx];
        end
    end

    ////////////////////
    // Clear strobe
    ////////////////////

    // Held entries stay put under back-pressure
    always_comb begin
        entry_clear          = '0;
        entry_clear[sel_idx] = sel_found & fu_ready;
    end

    // Clear is one-hot at most, lands on a ready entry, only with an issue
    always_comb begin
        assert final ($onehot0(entry_clear) && ((entry_clear & ~entry_ready) == '0)
                      && (entry_clear == '0 || issue_valid))
            else $error("rs_select: bad clear %b, ready %b", entry_clear, entry_ready);
    end

endmodule

// ==== src/rs_top.sv ====
/*
 * Reservation station top, one allocator, a bank of entries, one selector.
 * Single clock, reset asynchronous and active low.
 */

`timescale 1ns/100ps

module rs_top (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     alloc_valid,
    input  rs_pkg::rs_op_t           alloc_op,
    input  logic [rs_pkg::tag_w-1:0] alloc_dest,
    input  logic [rs_pkg::tag_w-1:0] alloc_src1_tag,
    input  logic                     alloc_src1_ready,
    input  rs_pkg::rs_operand_u      alloc_src2,
    input  logic                     alloc_src2_imm,
    input  logic                     alloc_src2_ready,
    input  logic                     cdb_valid,
    input  logic [rs_pkg::tag_w-1:0] cdb_tag,
    input  logic                     fu_ready,
    input  logic                     flush,
    output logic                     alloc_ready,
    output logic                     issue_valid,
    output rs_pkg::rs_op_t           issue_op,
    output logic [rs_pkg::tag_w-1:0] issue_dest,
    output logic [rs_pkg::tag_w-1:0] issue_src1_tag,
    output rs_pkg::rs_operand_u      issue_src2,
    output logic                     issue_src2_imm
);

    import rs_pkg::*;

    ////////////////////
    // Entry wires
    ////////////////////

    // Strobes into the bank
    logic [rs_size-1:0] entry_write;
    logic [rs_size-1:0] entry_clear;
    // Status out of the bank
    logic [rs_size-1:0] entry_valid;
    logic [rs_size-1:0] entry_ready;
    // Contents toward the selector
    rs_op_t             entry_op       [rs_size];
    logic [tag_w-1:0]   entry_dest     [rs_size];
    logic [tag_w-1:0]   entry_src1_tag [rs_size];
    rs_operand_u        entry_src2     [rs_size];
    logic [rs_size-1:0] entry_src2_imm;

    rs_alloc rs_alloc_i (
        .entry_valid (entry_valid),
        .alloc_valid (alloc_valid),
        .entry_write (entry_write),
        .alloc_ready (alloc_ready)
    );

    // Bank of identical entries, all sharing the dispatch fields and CDB
    for (genvar i = 0; i < rs_size; i++) begin : g_entry
        rs_entry rs_entry_i (
            .clock            (clock),
            .rst_n            (rst_n),
            .write            (entry_write[i]),
            .clear            (entry_clear[i]),
            .flush            (flush),
            .alloc_op         (alloc_op),
            .alloc_dest       (alloc_dest),
            .alloc_src1_tag   (alloc_src1_tag),
            .alloc_src1_ready (alloc_src1_ready),
            .alloc_src2       (alloc_src2),
            .alloc_src2_imm   (alloc_src2_imm),
            .alloc_src2_ready (alloc_src2_ready),
            .cdb_valid        (cdb_valid),
            .cdb_tag          (cdb_tag),
            .valid            (entry_valid[i]),
            .ready            (entry_ready[i]),
            .op               (entry_op[i]),
            .dest             (entry_dest[i]),
            .src1_tag         (entry_src1_tag[i]),
            .src2             (entry_src2[i]),
            .src2_imm         (entry_src2_imm[i])
        );
    end

    rs_select rs_select_i (
        .entry_ready    (entry_ready),
        .entry_op       (entry_op),
        .entry_dest     (entry_dest),
        .entry_src1_tag (entry_src1_tag),
        .entry_src2     (entry_src2),
        .entry_src2_imm (entry_src2_imm),
        .fu_ready       (fu_ready),
        .entry_clear    (entry_clear),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_dest     (issue_dest),
        .issue_src1_tag (issue_src1_tag),
        .issue_src2     (issue_src2),
        .issue_src2_imm (issue_src2_imm)
    );

endmodule

// ==== verif/rs_checker.sv ====
/*
 * Reference model of the eight-entry station, checked on every rising edge.
 * Only DUT ports are watched, plus the test markers from the testbench.
 * Reports one line per test with its first mismatch, then the counts.
 */

`timescale 1ns/100ps

module rs_checker (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     alloc_valid,
    input  logic [3:0]               alloc_op,
    input  logic [rs_pkg::tag_w-1:0] alloc_dest,
    input  logic [rs_pkg::tag_w-1:0] alloc_src1_tag,
    input  logic                     alloc_src1_ready,
    input  logic [7:0]               alloc_src2,
    input  logic                     alloc_src2_imm,
    input  logic                     alloc_src2_ready,
    input  logic                     cdb_valid,
    input  logic [rs_pkg::tag_w-1:0] cdb_tag,
    input  logic                     fu_ready,
    input  logic                     flush,
    input  logic                     alloc_ready,
    input  logic                     issue_valid,
    input  logic [3:0]               issue_op,
    input  logic [rs_pkg::tag_w-1:0] issue_dest,
    input  logic [rs_pkg::tag_w-1:0] issue_src1_tag,
    input  logic [7:0]               issue_src2,
    input  logic                     issue_src2_imm,
    input  logic [95:0]              test_name,
    input  logic                     test_done,
    input  logic                     run_done,
    output int                       pass_count,
    output int                       fail_count
);

    import rs_pkg::*;

    ////////////////////
    // Model state
    ////////////////////

    logic             m_valid [rs_size];
    logic             m_r1    [rs_size];
    logic             m_r2    [rs_size];
    logic [3:0]       m_op    [rs_size];
    logic [tag_w-1:0] m_dest  [rs_size];
    logic [tag_w-1:0] m_s1    [rs_size];
    logic [7:0]       m_s2    [rs_size];
    logic             m_imm   [rs_size];

    // Per-test mismatch record
    int         err_cnt;
    string      first_what;
    logic [7:0] first_exp;
    logic [7:0] first_act;

    // Keeps only the first mismatch of a test for its report line
    task automatic check(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            if (err_cnt == 0) begin
                first_what = what;
                first_exp  = exp;
                first_act  = act;
            end
            err_cnt++;
        end
    endtask

    ////////////////////
    // Compare and step
    ////////////////////

    always @(posedge clock or negedge rst_n) begin
        int   sel;
        int   free;
        logic exp_iv;
        if (!rst_n) begin
            for (int i = 0; i < rs_size; i++) begin
                m_valid[i] = 1'b0;
            end
            err_cnt    = 0;
            pass_count = 0;
            fail_count = 0;
        end else begin
            // Lowest ready and lowest free, from state before the edge
            sel  = -1;
            free = -1;
            for (int i = rs_size - 1; i >= 0; i--) begin
                if (m_valid[i] && m_r1[i] && m_r2[i]) sel = i;
                if (!m_valid[i]) free = i;
            end
            exp_iv = (sel >= 0);
            check("alloc_ready", 8'(free >= 0), 8'(alloc_ready));
            check("issue_valid", 8'(exp_iv), 8'(issue_valid));
            if (exp_iv && issue_valid) begin
                check("issue_op", 8'(m_op[sel]), 8'(issue_op));
                check("issue_dest", 8'(m_dest[sel]), 8'(issue_dest));
                check("issue_src1_tag", 8'(m_s1[sel]), 8'(issue_src1_tag));
                check("issue_src2", m_s2[sel], issue_src2);
                check("issue_src2_imm", 8'(m_imm[sel]), 8'(issue_src2_imm));
            end
            if (flush) begin
                // Mispredict wipes everything, same-cycle allocation included
                for (int i = 0; i < rs_size; i++) begin
                    m_valid[i] = 1'b0;
                end
            end else begin
                // Wakeup of waiting entries
                for (int i = 0; i < rs_size; i++) begin
                    if (m_valid[i] && cdb_valid && m_s1[i] == cdb_tag) m_r1[i] = 1'b1;
                    if (m_valid[i] && cdb_valid && !m_imm[i] && m_s2[i][tag_w-1:0] == cdb_tag)
                        m_r2[i] = 1'b1;
                end
                if (exp_iv && fu_ready) m_valid[sel] = 1'b0;
                if (alloc_valid && free >= 0) begin
                    m_valid[free] = 1'b1;
                    m_op[free]    = alloc_op;
                    m_dest[free]  = alloc_dest;
                    m_s1[free]    = alloc_src1_tag;
                    m_s2[free]    = alloc_src2;
                    m_imm[free]   = alloc_src2_imm;
                    m_r1[free]    = alloc_src1_ready || (cdb_valid && cdb_tag == alloc_src1_tag);
                    m_r2[free]    = alloc_src2_ready || alloc_src2_imm
                                    || (cdb_valid && cdb_tag == alloc_src2[tag_w-1:0]);
                end
            end
            // Test boundary
            if (test_done) begin
                if (err_cnt == 0) begin
                    $display("PASS %0s", test_name);
                    pass_count++;
                end else begin
                    $display("FAIL %0s %0s expected %h actual %h (%0d mismatches)",
                             test_name, first_what, first_exp, first_act, err_cnt);
                    fail_count++;
                end
                err_cnt = 0;
            end
            if (run_done) begin
                // Mismatches seen after the last test closed
                if (err_cnt != 0) begin
                    $display("%0d mismatches after the last test, first on %0s",
                             err_cnt, first_what);
                    fail_count++;
                end
                $display("summary: %0d pass, %0d fail", pass_count, fail_count);
            end
        end
    end

endmodule

// ==== verif/rs_tb.sv ====
/*
 * Testbench for the station, standing in for dispatch, the CDB and the FU.
 * One table row per cycle, driven on the falling edge.
 * Table rows never allocate into a full station.
 */

`timescale 1ns/100ps

module rs_tb;

    import rs_pkg::*;

    // How a row sets fu_ready
    typedef enum logic [1:0] {fu_lo, fu_hi, fu_rnd} fu_mode_t;

    typedef struct packed {
        logic [95:0]      name;
        logic             av;
        logic [tag_w-1:0] dest;
        logic [tag_w-1:0] s1;
        logic             s1r;
        logic [7:0]       s2;
        logic             s2i;
        logic             s2r;
        logic             cv;
        logic [tag_w-1:0] ct;
        fu_mode_t         fu;
        logic             fl;
        logic             last;
    } row_t;

    logic clock = 1'b0;
    logic rst_n;
    logic alloc_valid, alloc_src1_ready, alloc_src2_imm, alloc_src2_ready;
    logic cdb_valid, fu_ready, flush;
    logic alloc_ready, issue_valid, issue_src2_imm;
    rs_op_t           alloc_op, issue_op;
    logic [tag_w-1:0] alloc_dest, alloc_src1_tag, cdb_tag, issue_dest, issue_src1_tag;
    rs_operand_u      alloc_src2, issue_src2;

    // Test markers toward the checker
    logic [95:0] test_name;
    logic        test_done;
    logic        run_done;
    int          pass_count;
    int          fail_count;

    // Stimulus table
    row_t        rows [$];
    logic [95:0] cur_name;
    int          test_count = 0;
    logic        table_ready = 1'b0;
    logic [31:0] lfsr = 32'h917a;

    always #4 clock = ~clock;

    ////////////////////
    // Table helpers
    ////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic put(input logic av, input logic [5:0] dest, input logic [5:0] s1,
                       input logic s1r, input logic [7:0] s2, input logic s2i, input logic s2r,
                       input logic cv, input logic [5:0] ct, input fu_mode_t fu,
                       input logic fl, input logic last);
        row_t r;
        r = '{cur_name, av, dest, s1, s1r, s2, s2i, s2r, cv, ct, fu, fl, last};
        rows.push_back(r);
    endtask

    task automatic alloc(input logic [5:0] dest, input logic [5:0] s1, input logic s1r,
                         input logic [7:0] s2, input logic s2i, input logic s2r,
                         input fu_mode_t fu);
        put(1'b1, dest, s1, s1r, s2, s2i, s2r, 1'b0, 6'd0, fu, 1'b0, 1'b0);
    endtask

    task automatic idle(input logic cv, input logic [5:0] ct, input fu_mode_t fu, input logic fl);
        put(1'b0, 6'd0, 6'd0, 1'b0, 8'd0, 1'b0, 1'b0, cv, ct, fu, fl, 1'b0);
    endtask

    task automatic start_test(input logic [95:0] nm);
        cur_name = nm;
        test_count++;
    endtask

    // Drain cycles with the FU open, the last one closes the test
    task automatic end_test(input int n);
        for (int k = 1; k < n; k++) idle(1'b0, 6'd0, fu_hi, 1'b0);
        put(1'b0, 6'd0, 6'd0, 1'b0, 8'd0, 1'b0, 1'b0, 1'b0, 6'd0, fu_hi, 1'b0, 1'b1);
    endtask

    task automatic apply_row(input row_t r);
        alloc_valid      = r.av;
        alloc_op         = rs_op_t'({1'b0, r.dest[2:0]});
        alloc_dest       = r.dest;
        alloc_src1_tag   = r.s1;
        alloc_src1_ready = r.s1r;
        alloc_src2       = r.s2;
        alloc_src2_imm   = r.s2i;
        alloc_src2_ready = r.s2r;
        cdb_valid        = r.cv;
        cdb_tag          = r.ct;
        flush            = r.fl;
        test_name        = r.name;
        test_done        = r.last;
        if (r.fu == fu_rnd) begin
            lfsr     = lfsr_step(lfsr);
            fu_ready = lfsr[0];
        end else begin
            fu_ready = (r.fu == fu_hi);
        end
    endtask

    task automatic build_table();
        start_test("ready_alloc");
        alloc(6'd5, 6'd1, 1'b1, 8'h02, 1'b0, 1'b1, fu_hi);
        // Immediate src2 passes through untouched
        alloc(6'd6, 6'd3, 1'b1, 8'ha5, 1'b1, 1'b0, fu_hi);
        end_test(3);

        start_test("wakeup");
        alloc(6'd10, 6'd11, 1'b0, 8'd12, 1'b0, 1'b0, fu_hi);
        idle(1'b0, 6'd0, fu_hi, 1'b0);
        idle(1'b1, 6'd11, fu_hi, 1'b0);
        idle(1'b0, 6'd0, fu_hi, 1'b0);
        idle(1'b1, 6'd12, fu_hi, 1'b0);
        // Broadcast in the allocation cycle
        put(1'b1, 6'd13, 6'd14, 1'b0, 8'h3c, 1'b1, 1'b0, 1'b1, 6'd14, fu_hi, 1'b0, 1'b0);
        end_test(3);

        start_test("select_order");
        alloc(6'd20, 6'd30, 1'b0, 8'd21, 1'b0, 1'b1, fu_lo);
        alloc(6'd21, 6'd1, 1'b1, 8'd2, 1'b0, 1'b1, fu_lo);
        alloc(6'd22, 6'd31, 1'b0, 8'd2, 1'b0, 1'b1, fu_lo);
        // Entry 1 leaves, the next alloc must land there
        idle(1'b0, 6'd0, fu_hi, 1'b0);
        alloc(6'd23, 6'd1, 1'b1, 8'h7f, 1'b1, 1'b0, fu_lo);
        idle(1'b1, 6'd31, fu_lo, 1'b0);
        idle(1'b1, 6'd30, fu_lo, 1'b0);
        end_test(5);

        start_test("backpressure");
        for (int k = 0; k < 3; k++) alloc(6'(40 + k), 6'd1, 1'b1, 8'(k), 1'b0, 1'b1, fu_lo);
        for (int k = 0; k < 3; k++) idle(1'b0, 6'd0, fu_lo, 1'b0);
        // At most eight live entries even if the FU never opens
        for (int k = 0; k < 5; k++) begin
            alloc(6'(43 + k), 6'd1, 1'b1, 8'(8'h10 + k), 1'b0, 1'b1, fu_rnd);
            idle(1'b0, 6'd0, fu_rnd, 1'b0);
        end
        end_test(10);

        start_test("fill_flush");
        for (int k = 0; k < 7; k++) alloc(6'(50 + k), 6'd50, 1'b0, 8'd3, 1'b0, 1'b1, fu_lo);
        alloc(6'd57, 6'd1, 1'b1, 8'd3, 1'b0, 1'b1, fu_lo);
        idle(1'b0, 6'd0, fu_lo, 1'b0);
        idle(1'b0, 6'd0, fu_lo, 1'b1);
        idle(1'b1, 6'd50, fu_hi, 1'b0);
        // Lost to the flush
        put(1'b1, 6'd61, 6'd1, 1'b1, 8'd5, 1'b0, 1'b1, 1'b0, 6'd0, fu_hi, 1'b1, 1'b0);
        end_test(3);
    endtask

    ////////////////////
    // DUT and checker
    ////////////////////

    rs_top rs_top_i (
        .clock (clock), .rst_n (rst_n), .alloc_valid (alloc_valid), .alloc_op (alloc_op),
        .alloc_dest (alloc_dest), .alloc_src1_tag (alloc_src1_tag),
        .alloc_src1_ready (alloc_src1_ready), .alloc_src2 (alloc_src2),
        .alloc_src2_imm (alloc_src2_imm), .alloc_src2_ready (alloc_src2_ready),
        .cdb_valid (cdb_valid), .cdb_tag (cdb_tag), .fu_ready (fu_ready), .flush (flush),
        .alloc_ready (alloc_ready), .issue_valid (issue_valid), .issue_op (issue_op),
        .issue_dest (issue_dest), .issue_src1_tag (issue_src1_tag),
        .issue_src2 (issue_src2), .issue_src2_imm (issue_src2_imm)
    );

    rs_checker rs_checker_i (
        .clock (clock), .rst_n (rst_n), .alloc_valid (alloc_valid), .alloc_op (alloc_op),
        .alloc_dest (alloc_dest), .alloc_src1_tag (alloc_src1_tag),
        .alloc_src1_ready (alloc_src1_ready), .alloc_src2 (alloc_src2),
        .alloc_src2_imm (alloc_src2_imm), .alloc_src2_ready (alloc_src2_ready),
        .cdb_valid (cdb_valid), .cdb_tag (cdb_tag), .fu_ready (fu_ready), .flush (flush),
        .alloc_ready (alloc_ready), .issue_valid (issue_valid), .issue_op (issue_op),
        .issue_dest (issue_dest), .issue_src1_tag (issue_src1_tag),
        .issue_src2 (issue_src2), .issue_src2_imm (issue_src2_imm),
        .test_name (test_name), .test_done (test_done), .run_done (run_done),
        .pass_count (pass_count), .fail_count (fail_count)
    );

    ////////////////////
    // Run
    ////////////////////

    initial begin
        row_t quiet;
        quiet    = '0;
        run_done = 1'b0;
        rst_n    = 1'b0;
        apply_row(quiet);
        build_table();
        table_ready = 1'b1;
        repeat (10) @(negedge clock);
        rst_n = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
            @(negedge clock);
        end
        apply_row(quiet);
        run_done = 1'b1;
        @(posedge clock);
        #1;
        if (fail_count == 0 && pass_count == test_count) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog, table length in cycles plus margin
    initial begin
        wait (table_ready);
        #(rows.size() * 8 + 200);
        $display("watchdog: run did not finish in time, stopping");
        $display("TESTS FAILED");
        $finish;
    end

endmodule
